/* src/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Memory depths in 32-bit words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// Primary opcodes, instr[31:26]
`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_LW    6'h23
`define OP_SW    6'h2b
`define OP_BEQ   6'h04

// R-type function codes, instr[5:0]
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_SLT 6'h2a

// Operand forwarding selects
`define FWD_NONE 2'b00
`define FWD_WB   2'b01
`define FWD_MEM  2'b10

// ALU operations
`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR  3'd3
`define ALU_SLT 3'd4

`endif

/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  pc_t;
    typedef logic [2:0]  alu_ctrl_t;
    typedef logic [1:0]  fwd_sel_t;

    // Decoded control flags, all zero for a bubble
    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        logic      alu_src;
        logic      reg_dst;
        logic      branch;
        alu_ctrl_t alu_ctrl;
    } ctrl_t;

    // One program word on the load port
    typedef struct packed {
        pc_t   addr;
        word_t data;
    } imem_load_t;

    // ****************************************
    // Stage registers
    // ****************************************
    typedef struct packed {
        logic  valid;
        pc_t   pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        pc_t       pc;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        word_t     data_a;
        word_t     data_b;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
        pc_t       branch_target;
        logic      zero;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      mem_to_reg;
        word_t     read_data;
        word_t     alu_result;
        reg_addr_t dest;
    } mem_wb_t;

endpackage

`default_nettype wire

/* src/instruction_fetch.sv */
`default_nettype none
`timescale 1ns/10ps
`include "mips_consts.svh"

module instruction_fetch (
    input  logic                 pipeline_clock,
    input  logic                 arst_n,
    input  logic                 run,
    input  logic                 load_valid,
    input  mips_pkg::imem_load_t load,
    input  logic                 stall,
    input  logic                 branch_taken,
    input  mips_pkg::pc_t        branch_target,
    output logic                 load_ready,
    output mips_pkg::if_id_t     if_id
);

    mips_pkg::word_t imem [`IMEM_DEPTH];
    mips_pkg::pc_t   pc;

    // Loading is only allowed while the core is halted
    assign load_ready = ~run;

    // Instruction memory and its program-load write
    always_ff @(posedge pipeline_clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `IMEM_DEPTH; i++) begin
                imem[i] <= '0;
            end
        end else if (load_valid && load_ready) begin
            imem[load.addr] <= load.data;
        end
    end

    // PC and fetch/decode register
    always_ff @(posedge pipeline_clock or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= '0;
            if_id <= '0;
        end else if (!run) begin
            // Halted, drain with bubbles
            pc    <= '0;
            if_id <= '0;
        end else if (branch_taken) begin
            pc    <= branch_target;
            if_id <= '0;
        end else if (!stall) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= imem[pc];
            pc          <= pc + 8'd1;
        end
    end

endmodule

`default_nettype wire

/* src/instruction_decode.sv */
`default_nettype none
`timescale 1ns/10ps
`include "mips_consts.svh"

module instruction_decode (
    input  logic                pipeline_clock,
    input  logic                arst_n,
    input  mips_pkg::if_id_t    if_id,
    input  logic                stall,
    input  logic                branch_taken,
    input  logic                wb_en,
    input  mips_pkg::reg_addr_t wb_dest,
    input  mips_pkg::word_t     wb_data,
    input  mips_pkg::reg_addr_t dbg_reg_addr,
    output mips_pkg::id_ex_t    id_ex,
    output mips_pkg::word_t     dbg_reg_data
);

    mips_pkg::word_t     regs [32];
    mips_pkg::ctrl_t     ctrl;
    mips_pkg::id_ex_t    id_ex_next;
    logic [5:0]          opcode;
    logic [5:0]          funct;

    // Register read with same-cycle write-back bypass
    function automatic mips_pkg::word_t read_reg(input mips_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_en && wb_dest == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    assign opcode = if_id.instr[31:26];
    assign funct  = if_id.instr[5:0];

    // ****************************************
    // Control decode
    // ****************************************
    always_comb begin
        ctrl = '0;
        if (if_id.valid) begin
            case (opcode)
                `OP_RTYPE: begin
                    ctrl.reg_dst   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    case (funct)
                        `FN_ADD: ctrl.alu_ctrl = `ALU_ADD;
                        `FN_SUB: ctrl.alu_ctrl = `ALU_SUB;
                        `FN_AND: ctrl.alu_ctrl = `ALU_AND;
                        `FN_OR:  ctrl.alu_ctrl = `ALU_OR;
                        `FN_SLT: ctrl.alu_ctrl = `ALU_SLT;
                        // Unknown function, no-op
                        default: ctrl = '0;
                    endcase
                end
                `OP_ADDI: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
                `OP_LW: begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.mem_read   = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    ctrl.alu_src    = 1'b1;
                end
                `OP_SW: begin
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
                `OP_BEQ: begin
                    ctrl.branch   = 1'b1;
                    ctrl.alu_ctrl = `ALU_SUB;
                end
                default: ctrl = '0;
            endcase
        end
    end

    always_comb begin
        id_ex_next.valid  = if_id.valid;
        id_ex_next.ctrl   = ctrl;
        id_ex_next.pc     = if_id.pc;
        id_ex_next.rs     = if_id.instr[25:21];
        id_ex_next.rt     = if_id.instr[20:16];
        id_ex_next.rd     = if_id.instr[15:11];
        id_ex_next.data_a = read_reg(if_id.instr[25:21]);
        id_ex_next.data_b = read_reg(if_id.instr[20:16]);
        id_ex_next.imm    = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
        dbg_reg_data      = read_reg(dbg_reg_addr);
    end

    // Register file, r0 stays zero
    always_ff @(posedge pipeline_clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_dest != '0) begin
            regs[wb_dest] <= wb_data;
        end
    end

    always_ff @(posedge pipeline_clock or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (stall || branch_taken) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_next;
        end
    end

endmodule

`default_nettype wire

/* src/execute.sv */
`default_nettype none
`timescale 1ns/10ps
`include "mips_consts.svh"

module execute (
    input  logic               pipeline_clock,
    input  logic               arst_n,
    input  mips_pkg::id_ex_t   id_ex,
    input  mips_pkg::fwd_sel_t fwd_a,
    input  mips_pkg::fwd_sel_t fwd_b,
    input  mips_pkg::word_t    mem_fwd_data,
    input  mips_pkg::word_t    wb_data,
    input  logic               branch_taken,
    output mips_pkg::ex_mem_t  ex_mem
);

    mips_pkg::word_t   operand_a;
    mips_pkg::word_t   operand_b;
    mips_pkg::word_t   alu_b;
    mips_pkg::word_t   alu_result;
    mips_pkg::ex_mem_t ex_mem_next;

    // Forwarding muxes, memory stage is the newer source
    always_comb begin
        case (fwd_a)
            `FWD_MEM: operand_a = mem_fwd_data;
            `FWD_WB:  operand_a = wb_data;
            default:  operand_a = id_ex.data_a;
        endcase
        case (fwd_b)
            `FWD_MEM: operand_b = mem_fwd_data;
            `FWD_WB:  operand_b = wb_data;
            default:  operand_b = id_ex.data_b;
        endcase
    end

    assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : operand_b;

    // ALU
    always_comb begin
        case (id_ex.ctrl.alu_ctrl)
            `ALU_SUB: alu_result = operand_a - alu_b;
            `ALU_AND: alu_result = operand_a & alu_b;
            `ALU_OR:  alu_result = operand_a | alu_b;
            `ALU_SLT: alu_result = {31'd0, $signed(operand_a) < $signed(alu_b)};
            default:  alu_result = operand_a + alu_b;
        endcase
    end

    always_comb begin
        ex_mem_next.valid         = id_ex.valid;
        ex_mem_next.ctrl          = id_ex.ctrl;
        ex_mem_next.alu_result    = alu_result;
        ex_mem_next.store_data    = operand_b;
        ex_mem_next.dest          = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
        // Word offset relative to the next PC
        ex_mem_next.branch_target = id_ex.pc + 8'd1 + id_ex.imm[7:0];
        ex_mem_next.zero          = (alu_result == '0);
    end

    always_ff @(posedge pipeline_clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (branch_taken) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_mem_next;
        end
    end

endmodule

`default_nettype wire

/* src/memory_access.sv */
`default_nettype none
`timescale 1ns/10ps
`include "mips_consts.svh"

module memory_access (
    input  logic                pipeline_clock,
    input  logic                arst_n,
    input  mips_pkg::ex_mem_t   ex_mem,
    output mips_pkg::word_t     mem_fwd_data,
    output logic                branch_taken,
    output mips_pkg::pc_t       branch_target,
    output logic                wb_en,
    output mips_pkg::reg_addr_t wb_dest,
    output mips_pkg::word_t     wb_data
);

    mips_pkg::word_t                  dmem [`DMEM_DEPTH];
    logic [$clog2(`DMEM_DEPTH)-1:0]   dmem_addr;
    mips_pkg::mem_wb_t                mem_wb;

    // Word index taken straight from the ALU result
    assign dmem_addr = ex_mem.alu_result[$clog2(`DMEM_DEPTH)-1:0];

    always_ff @(posedge pipeline_clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.ctrl.mem_write) begin
            dmem[dmem_addr] <= ex_mem.store_data;
        end
    end

    // Branch resolves here
    assign branch_taken  = ex_mem.valid & ex_mem.ctrl.branch & ex_mem.zero;
    assign branch_target = ex_mem.branch_target;
    assign mem_fwd_data  = ex_mem.alu_result;

    always_ff @(posedge pipeline_clock or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid      <= ex_mem.valid;
            mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
            mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
            mem_wb.read_data  <= dmem[dmem_addr];
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.dest       <= ex_mem.dest;
        end
    end

    // Write-back select
    assign wb_en   = mem_wb.valid & mem_wb.reg_write;
    assign wb_dest = mem_wb.dest;
    assign wb_data = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
`default_nettype none
`timescale 1ns/10ps
`include "mips_consts.svh"

module hazard_unit (
    input  mips_pkg::reg_addr_t if_id_rs,
    input  mips_pkg::reg_addr_t if_id_rt,
    input  mips_pkg::reg_addr_t id_ex_rs,
    input  mips_pkg::reg_addr_t id_ex_rt,
    input  logic                id_ex_mem_read,
    input  mips_pkg::reg_addr_t ex_mem_dest,
    input  logic                ex_mem_reg_write,
    input  mips_pkg::reg_addr_t mem_wb_dest,
    input  logic                mem_wb_reg_write,
    output mips_pkg::fwd_sel_t  fwd_a,
    output mips_pkg::fwd_sel_t  fwd_b,
    output logic                stall
);

    // Newest producer first, r0 never forwarded
    function automatic mips_pkg::fwd_sel_t fwd_select(input mips_pkg::reg_addr_t src);
        if (ex_mem_reg_write && ex_mem_dest != '0 && ex_mem_dest == src) begin
            return `FWD_MEM;
        end else if (mem_wb_reg_write && mem_wb_dest != '0 && mem_wb_dest == src) begin
            return `FWD_WB;
        end
        return `FWD_NONE;
    endfunction

    always_comb begin
        fwd_a = fwd_select(id_ex_rs);
        fwd_b = fwd_select(id_ex_rt);
    end

    // Load-use, hold one cycle until the load reaches write-back
    assign stall = id_ex_mem_read && id_ex_rt != '0
                   && (id_ex_rt == if_id_rs || id_ex_rt == if_id_rt);

endmodule

`default_nettype wire

/* src/pipeline.sv */
`default_nettype none
`timescale 1ns/10ps

module pipeline (
    input  logic                 pipeline_clock,
    input  logic                 arst_n,
    input  logic                 run,
    input  logic                 load_valid,
    input  mips_pkg::imem_load_t load,
    output logic                 load_ready,
    input  mips_pkg::reg_addr_t  dbg_reg_addr,
    output mips_pkg::word_t      dbg_reg_data
);

    mips_pkg::if_id_t    if_id;
    mips_pkg::id_ex_t    id_ex;
    mips_pkg::ex_mem_t   ex_mem;
    mips_pkg::fwd_sel_t  fwd_a;
    mips_pkg::fwd_sel_t  fwd_b;
    mips_pkg::word_t     mem_fwd_data;
    mips_pkg::word_t     wb_data;
    mips_pkg::reg_addr_t wb_dest;
    mips_pkg::pc_t       branch_target;
    logic                wb_en;
    logic                branch_taken;
    logic                stall;

    // ****************************************
    // Stages
    // ****************************************
    instruction_fetch u_instruction_fetch (
        .pipeline_clock (pipeline_clock),
        .arst_n         (arst_n),
        .run            (run),
        .load_valid     (load_valid),
        .load           (load),
        .stall          (stall),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .load_ready     (load_ready),
        .if_id          (if_id)
    );

    instruction_decode u_instruction_decode (
        .pipeline_clock (pipeline_clock),
        .arst_n         (arst_n),
        .if_id          (if_id),
        .stall          (stall),
        .branch_taken   (branch_taken),
        .wb_en          (wb_en),
        .wb_dest        (wb_dest),
        .wb_data        (wb_data),
        .dbg_reg_addr   (dbg_reg_addr),
        .id_ex          (id_ex),
        .dbg_reg_data   (dbg_reg_data)
    );

    execute u_execute (
        .pipeline_clock (pipeline_clock),
        .arst_n         (arst_n),
        .id_ex          (id_ex),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .mem_fwd_data   (mem_fwd_data),
        .wb_data        (wb_data),
        .branch_taken   (branch_taken),
        .ex_mem         (ex_mem)
    );

    memory_access u_memory_access (
        .pipeline_clock (pipeline_clock),
        .arst_n         (arst_n),
        .ex_mem         (ex_mem),
        .mem_fwd_data   (mem_fwd_data),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .wb_en          (wb_en),
        .wb_dest        (wb_dest),
        .wb_data        (wb_data)
    );

    // Bubbles and squashed slots carry zero control flags
    hazard_unit u_hazard_unit (
        .if_id_rs         (if_id.instr[25:21]),
        .if_id_rt         (if_id.instr[20:16]),
        .id_ex_rs         (id_ex.rs),
        .id_ex_rt         (id_ex.rt),
        .id_ex_mem_read   (id_ex.ctrl.mem_read),
        .ex_mem_dest      (ex_mem.dest),
        .ex_mem_reg_write (ex_mem.ctrl.reg_write),
        .mem_wb_dest      (wb_dest),
        .mem_wb_reg_write (wb_en),
        .fwd_a            (fwd_a),
        .fwd_b            (fwd_b),
        .stall            (stall)
    );

endmodule

`default_nettype wire

/* bench/pipeline_asserts.sv */
`default_nettype none
`timescale 1ns/10ps
`include "mips_consts.svh"

module pipeline_asserts (
    input logic                pipeline_clock,
    input logic                arst_n,
    input logic                run,
    input logic                load_ready,
    input logic                stall,
    input logic                branch_taken,
    input logic                id_ex_valid,
    input mips_pkg::reg_addr_t id_ex_rs,
    input mips_pkg::reg_addr_t id_ex_rt,
    input logic                ex_mem_mem_read,
    input mips_pkg::reg_addr_t ex_mem_dest,
    input mips_pkg::fwd_sel_t  fwd_a,
    input mips_pkg::fwd_sel_t  fwd_b
);

    // Load port closed while the core runs
    load_closed_while_running: assert property (
        @(posedge pipeline_clock) disable iff (!arst_n) run |-> !load_ready
    ) else $error("load_ready high while run is high");

    // The stalling load moves on with a real destination and leaves a bubble
    stall_needs_load_dest: assert property (
        @(posedge pipeline_clock) disable iff (!arst_n)
        (stall && !branch_taken) |=> (ex_mem_mem_read && ex_mem_dest != '0 && !id_ex_valid)
    ) else $error("stall without a load to a nonzero register");

    // r0 is never forwarded
    fwd_a_zero_source: assert property (
        @(posedge pipeline_clock) disable iff (!arst_n)
        (id_ex_rs == '0) |-> (fwd_a == `FWD_NONE)
    ) else $error("fwd_a active for source register 0");

    fwd_b_zero_source: assert property (
        @(posedge pipeline_clock) disable iff (!arst_n)
        (id_ex_rt == '0) |-> (fwd_b == `FWD_NONE)
    ) else $error("fwd_b active for source register 0");

endmodule

bind pipeline pipeline_asserts u_pipeline_asserts (
    .pipeline_clock  (pipeline_clock),
    .arst_n          (arst_n),
    .run             (run),
    .load_ready      (load_ready),
    .stall           (stall),
    .branch_taken    (branch_taken),
    .id_ex_valid     (id_ex.valid),
    .id_ex_rs        (id_ex.rs),
    .id_ex_rt        (id_ex.rt),
    .ex_mem_mem_read (ex_mem.ctrl.mem_read),
    .ex_mem_dest     (ex_mem.dest),
    .fwd_a           (fwd_a),
    .fwd_b           (fwd_b)
);

`default_nettype wire

/* bench/pipeline_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module pipeline_tb;

    // addi r31, r0, 0x5a5, offered on the load port while the core runs
    localparam logic [31:0] POISON_WORD = 32'h201f05a5;

    logic                 pipeline_clock;
    logic                 arst_n;
    logic                 run;
    logic                 load_valid;
    mips_pkg::imem_load_t load;
    logic                 load_ready;
    mips_pkg::reg_addr_t  dbg_reg_addr;
    mips_pkg::word_t      dbg_reg_data;

    // Test data tables, indexed per test through the first/num queues
    string       test_name[$];
    int          prog_first[$];
    int          prog_num[$];
    int          exp_first[$];
    int          exp_num[$];
    logic [7:0]  prog_addr[$];
    logic [31:0] prog_word[$];
    int          exp_reg[$];
    logic [31:0] exp_val[$];

    int error_count;
    int check_count;
    int failed_tests;
    int watchdog_cycles;

    pipeline DUT (
        .pipeline_clock (pipeline_clock),
        .arst_n         (arst_n),
        .run            (run),
        .load_valid     (load_valid),
        .load           (load),
        .load_ready     (load_ready),
        .dbg_reg_addr   (dbg_reg_addr),
        .dbg_reg_data   (dbg_reg_data)
    );

    initial begin
        pipeline_clock = 1'b0;
        forever #2 pipeline_clock = ~pipeline_clock;
    end

    // ****************************************
    // Helpers
    // ****************************************
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic apply_reset();
        @(posedge pipeline_clock);
        arst_n     <= 1'b0;
        run        <= 1'b0;
        load_valid <= 1'b0;
        repeat (4) @(posedge pipeline_clock);
        arst_n <= 1'b1;
        @(posedge pipeline_clock);
    endtask

    task automatic load_word(input logic [7:0] addr, input logic [31:0] data);
        load_valid <= 1'b1;
        load.addr  <= addr;
        load.data  <= data;
        // Word is taken on the first edge that sees load_ready
        @(posedge pipeline_clock);
        while (!load_ready) begin
            @(posedge pipeline_clock);
        end
    endtask

    task automatic read_register(input int num, output logic [31:0] value);
        dbg_reg_addr <= 5'(num);
        @(posedge pipeline_clock);
        value = dbg_reg_data;
    endtask

    task automatic read_testdata(output bit ok);
        int          fd;
        int          n;
        int          addr;
        int          reg_num;
        logic [31:0] word;
        string       line;
        string       name;
        ok = 1'b0;
        fd = $fopen("bench/pipeline_testdata.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) == "T") begin
                    n = $sscanf(line, "T %s", name);
                    test_name.push_back(name);
                    prog_first.push_back(prog_addr.size());
                    prog_num.push_back(0);
                    exp_first.push_back(exp_reg.size());
                    exp_num.push_back(0);
                end else if (n > 0 && line.getc(0) == "P") begin
                    n = $sscanf(line, "P %h %h", addr, word);
                    prog_addr.push_back(8'(addr));
                    prog_word.push_back(word);
                    prog_num[prog_num.size() - 1] += 1;
                end else if (n > 0 && line.getc(0) == "E") begin
                    n = $sscanf(line, "E %d %h", reg_num, word);
                    exp_reg.push_back(reg_num);
                    exp_val.push_back(word);
                    exp_num[exp_num.size() - 1] += 1;
                end
            end
            $fclose(fd);
            ok = (test_name.size() > 0);
        end
    endtask

    task automatic run_test(input int t);
        logic [31:0] value;
        logic [7:0]  top_addr;
        int          errors_before;
        int          idx;
        errors_before = error_count;
        apply_reset();

        // Register file must come out of reset cleared
        for (int r = 0; r < 32; r++) begin
            read_register(r, value);
            check_value($sformatf("dbg_reg_data[%0d] after reset", r), value, 32'h0);
        end

        top_addr = '0;
        for (int i = 0; i < prog_num[t]; i++) begin
            idx = prog_first[t] + i;
            load_word(prog_addr[idx], prog_word[idx]);
            if (prog_addr[idx] > top_addr) begin
                top_addr = prog_addr[idx];
            end
        end

        // Run with a word held on the closed load port
        run        <= 1'b1;
        load_valid <= 1'b1;
        load.addr  <= top_addr + 8'd3;
        load.data  <= POISON_WORD;
        @(posedge pipeline_clock);
        check_value("load_ready", 32'(load_ready), 32'h0);
        repeat (prog_num[t] + 20) @(posedge pipeline_clock);
        run        <= 1'b0;
        load_valid <= 1'b0;
        @(posedge pipeline_clock);

        read_register(31, value);
        check_value("dbg_reg_data[31]", value, 32'h0);
        for (int k = 0; k < exp_num[t]; k++) begin
            idx = exp_first[t] + k;
            read_register(exp_reg[idx], value);
            check_value($sformatf("dbg_reg_data[%0d]", exp_reg[idx]), value, exp_val[idx]);
        end

        if (error_count != errors_before) begin
            failed_tests++;
            $display("test %s: FAIL, %0d mismatches", test_name[t], error_count - errors_before);
        end else begin
            $display("test %s: ok", test_name[t]);
        end
    endtask

    // ****************************************
    // Watchdog
    // ****************************************
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge pipeline_clock);
        $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Verification failed");
        $finish;
    end

    initial begin
        bit ok;
        int budget;
        arst_n          = 1'b0;
        run             = 1'b0;
        load_valid      = 1'b0;
        load            = '0;
        dbg_reg_addr    = '0;
        error_count     = 0;
        check_count     = 0;
        failed_tests    = 0;
        watchdog_cycles = 0;
        read_testdata(ok);
        if (!ok) begin
            $display("error: test data file could not be read or holds no test");
            $display("Verification failed");
            $finish;
        end else begin
            // Reset, register scan, load, run and readback per test, with margin
            budget = 0;
            foreach (test_name[i]) begin
                budget += 2 * prog_num[i] + exp_num[i] + 100;
            end
            watchdog_cycles = budget;
            foreach (test_name[i]) begin
                run_test(i);
            end
            $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                     test_name.size(), failed_tests, check_count, error_count);
            if (error_count == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* bench/pipeline_testdata.txt */
# T <name> starts a test; P <addr hex> <instruction hex> is one program word
# E <register decimal> <expected value hex>; text after the fields is ignored
T alu_forwarding
P 00 20010005 addi r1, r0, 5
P 01 2002fffd addi r2, r0, -3
P 02 00221820 add  r3, r1, r2
P 03 00612022 sub  r4, r3, r1
P 04 2006003e addi r6, r0, 0x3e
P 05 00862824 and  r5, r4, r6
P 06 00a13825 or   r7, r5, r1
P 07 0081402a slt  r8, r4, r1
P 08 0024482a slt  r9, r1, r4
P 09 00e55022 sub  r10, r7, r5
E 1 00000005
E 2 fffffffd
E 3 00000002
E 4 fffffffd
E 5 0000003c
E 6 0000003e
E 7 0000003d
E 8 00000001
E 9 00000000
E 10 00000001
T load_use
P 00 20011234 addi r1, r0, 0x1234
P 01 ac010004 sw   r1, 4(r0)
P 02 8c020004 lw   r2, 4(r0)
P 03 00411820 add  r3, r2, r1
P 04 8c040004 lw   r4, 4(r0)
P 05 00242820 add  r5, r1, r4
E 2 00001234
E 3 00002468
E 4 00001234
E 5 00002468
T store_load
P 00 20010055 addi r1, r0, 0x55
P 01 20020077 addi r2, r0, 0x77
P 02 ac010008 sw   r1, 8(r0)
P 03 ac020009 sw   r2, 9(r0)
P 04 20030008 addi r3, r0, 8
P 05 ac610002 sw   r1, 2(r3)
P 06 8c06000a lw   r6, 10(r0)
P 07 8c040008 lw   r4, 8(r0)
P 08 8c650001 lw   r5, 1(r3)
P 09 8c07000b lw   r7, 11(r0)
E 4 00000055
E 5 00000077
E 6 00000055
E 7 00000000
T branch
P 00 20010007 addi r1, r0, 7
P 01 20020007 addi r2, r0, 7
P 02 10220003 beq  r1, r2, 3
P 03 20030001 addi r3, r0, 1
P 04 20040001 addi r4, r0, 1
P 05 20050001 addi r5, r0, 1
P 06 10230002 beq  r1, r3, 2
P 07 20060002 addi r6, r0, 2
P 08 20070003 addi r7, r0, 3
E 3 00000000
E 4 00000000
E 5 00000000
E 6 00000002
E 7 00000003
T reg_zero
P 00 20000009 addi r0, r0, 9
P 01 00000820 add  r1, r0, r0
P 02 20020004 addi r2, r0, 4
P 03 00420020 add  r0, r2, r2
P 04 00021825 or   r3, r0, r2
P 05 2004ffff addi r4, r0, -1
P 06 00042822 sub  r5, r0, r4
E 0 00000000
E 1 00000000
E 2 00000004
E 3 00000004
E 4 ffffffff
E 5 00000001

/* pipeline.f */
+incdir+src
src/mips_pkg.sv
src/instruction_fetch.sv
src/instruction_decode.sv
src/execute.sv
src/memory_access.sv
src/hazard_unit.sv
src/pipeline.sv
bench/pipeline_asserts.sv
bench/pipeline_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module pipeline_tb -f pipeline.f
./obj_dir/Vpipeline_tb > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"
